// File: cluster_consts.svh
`ifndef CLUSTER_CONSTS_SVH
`define CLUSTER_CONSTS_SVH

// ==========================================================================
// Datapath widths
// ==========================================================================

`define SAMPLE_W 31 // Signed ADC sample.
`define RESULT_W 33 // Four samples plus two guard bits.

// ==========================================================================
// Cluster geometry and pacing
// ==========================================================================

`define CORE_COUNT 4 // Cores in the row.
`define WINDOW 4 // Samples per result.

// Clock cycles per ADC slot; the dispatch sequence needs at least 4.
`define SAMPLE_PERIOD 6

`endif

// File: dsp_types_pkg.sv
`include "cluster_consts.svh"

package dsp_types_pkg;

	// ======================================================================
	// Sample and result words
	// ======================================================================

	typedef logic signed [`SAMPLE_W-1:0] sample_t; // One ADC sample.

	typedef logic signed [`RESULT_W-1:0] result_t; // One window sum.

	// ======================================================================
	// Core output bundle
	// ======================================================================

	// One core's output, valid for the single cycle that en is high.
	typedef struct packed {
		logic en; // Result strobe.
		result_t data; // Window sum.
	} core_out_t;

endpackage

// File: ctrl_pkg.sv
package ctrl_pkg;

	// ======================================================================
	// Dispatcher sequencing
	// ======================================================================

	// One pass per sample slot, from tick to load and back.
	typedef enum logic [1:0] {
		IDLE = 2'd0, // Waiting for a slot tick.
		REQ = 2'd1, // Asking the source for a sample.
		WAIT = 2'd2, // Source updates the shared input.
		LOAD = 2'd3 // Selected core captures the sample.
	} dispatch_state_t;

endpackage

// File: pace_timer.sv
`timescale 1ns/1ps

`include "cluster_consts.svh"

module pace_timer (
	input logic clk,
	input logic rst_n,
	output logic tick
);

	localparam int CNT_W = $clog2(`SAMPLE_PERIOD);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`SAMPLE_PERIOD - 1);

	logic [CNT_W-1:0] cnt; // Position inside the slot.

	// ======================================================================
	// Slot counter
	// ======================================================================

	// Registered tick lands SAMPLE_PERIOD cycles after reset release.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt <= '0;
			tick <= 1'b0;
		end else if (cnt == CNT_LAST) begin
			cnt <= '0; // Wrap.
			tick <= 1'b1; // One pulse per slot.
		end else begin
			cnt <= cnt + 1'b1;
			tick <= 1'b0;
		end
	end

endmodule

// File: dispatch_fsm.sv
`timescale 1ns/1ps

`include "cluster_consts.svh"

module dispatch_fsm (
	input logic clk,
	input logic rst_n,
	input logic tick,
	output logic req,
	output logic [`CORE_COUNT-1:0] core_load
);

	import ctrl_pkg::*;

	localparam int IDX_W = $clog2(`CORE_COUNT);
	localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(`CORE_COUNT - 1);

	dispatch_state_t state; // Current step of the slot.
	dispatch_state_t state_nxt;
	logic [IDX_W-1:0] core_idx; // Core that gets the next sample.

	// ======================================================================
	// State register
	// ======================================================================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// ======================================================================
	// Next state
	// ======================================================================

	// A tick seen outside IDLE is dropped.
	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (tick) begin
					state_nxt = REQ;
				end
			end
			REQ: begin
				state_nxt = WAIT;
			end
			WAIT: begin
				state_nxt = LOAD; // Sample is stable from here.
			end
			LOAD: begin
				state_nxt = IDLE;
			end
			default: begin
				state_nxt = IDLE;
			end
		endcase
	end

	// ======================================================================
	// Round-robin core index
	// ======================================================================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			core_idx <= '0;
		end else if (state == LOAD) begin
			if (core_idx == IDX_LAST) begin
				core_idx <= '0;
			end else begin
				core_idx <= core_idx + 1'b1;
			end
		end
	end

	// ======================================================================
	// Outputs
	// ======================================================================

	assign req = (state == REQ); // One cycle per slot.

	// One-hot strobe to the indexed core while in LOAD.
	always_comb begin
		core_load = '0;
		for (int i = 0; i < `CORE_COUNT; i++) begin
			if (state == LOAD && core_idx == IDX_W'(i)) begin
				core_load[i] = 1'b1;
			end
		end
	end

endmodule

// File: window_core.sv
`timescale 1ns/1ps

`include "cluster_consts.svh"

module window_core (
	input logic clk,
	input logic rst_n,
	input logic load,
	input dsp_types_pkg::sample_t sample,
	output dsp_types_pkg::core_out_t out
);

	import dsp_types_pkg::*;

	localparam int FILL_W = $clog2(`WINDOW);
	localparam logic [FILL_W-1:0] FILL_LAST = FILL_W'(`WINDOW - 1);

	result_t sum; // Partial window total.
	result_t sample_ext;
	result_t total; // Sum including the sample now loaded.
	logic [FILL_W-1:0] fill; // Samples already in the window.
	logic last; // This load closes the window.
	logic en_q;
	result_t data_q;

	// Signed cast widens with copies of the sign bit.
	assign sample_ext = result_t'(sample);
	assign total = sum + sample_ext;
	assign last = load && (fill == FILL_LAST);

	// ======================================================================
	// Accumulator and fill count
	// ======================================================================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sum <= '0;
			fill <= '0;
			en_q <= 1'b0;
		end else begin
			en_q <= last; // High only in the cycle after.
			if (last) begin
				sum <= '0; // Start a new window.
				fill <= '0;
			end else if (load) begin
				sum <= total;
				fill <= fill + 1'b1;
			end
		end
	end

	// ======================================================================
	// Result register
	// ======================================================================

	// Holds the last full sum until the next window closes.
	always_ff @(posedge clk) begin
		if (last) begin
			data_q <= total;
		end
	end

	assign out.en = en_q;
	assign out.data = data_q;

endmodule

// File: sample_cluster.sv
`timescale 1ns/1ps

`include "cluster_consts.svh"

module sample_cluster (
	input logic clk,
	input logic rst_n,
	input dsp_types_pkg::sample_t sample,
	output logic req,
	output dsp_types_pkg::core_out_t core_out [`CORE_COUNT]
);

	logic tick; // Start of a sample slot.
	logic [`CORE_COUNT-1:0] core_load; // One-hot capture strobe.

	// ======================================================================
	// Slot pacing and dispatch
	// ======================================================================

	pace_timer u_pace_timer (
		.clk (clk),
		.rst_n (rst_n),
		.tick (tick)
	);

	dispatch_fsm u_dispatch_fsm (
		.clk (clk),
		.rst_n (rst_n),
		.tick (tick),
		.req (req),
		.core_load (core_load)
	);

	// ======================================================================
	// Core row
	// ======================================================================

	// All cores watch the shared input; only the strobed one captures.
	for (genvar i = 0; i < `CORE_COUNT; i++) begin : g_core
		window_core u_core (
			.clk (clk),
			.rst_n (rst_n),
			.load (core_load[i]),
			.sample (sample),
			.out (core_out[i])
		);
	end

endmodule

// File: sample_cluster_properties.sv
`timescale 1ns/1ps

`include "cluster_consts.svh"

module sample_cluster_properties (
	input logic clk,
	input logic rst_n,
	input logic tick,
	input logic req,
	input logic [`CORE_COUNT-1:0] core_load,
	input ctrl_pkg::dispatch_state_t state
);

	import ctrl_pkg::*;
	import dsp_types_pkg::*;

	// ======================================================================
	// Dispatcher protocol
	// ======================================================================

	a_req_pulse: assert property (@(posedge clk) disable iff (!rst_n) req |=> !req)
		else $error("req stayed high for more than one cycle");

	a_load_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(core_load))
		else $error("core_load has more than one bit set");

	// Two cycles from request to capture.
	a_load_after_req: assert property (@(posedge clk) disable iff (!rst_n)
		req |-> ##2 (core_load != '0))
		else $error("no core_load bit two cycles after req");

	a_load_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
		(core_load != '0) |-> $past(req, 2))
		else $error("core_load bit without a req two cycles earlier");

	// Slot ticks only arrive once the previous pass is over.
	a_tick_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
		tick |-> (state == IDLE))
		else $error("slot tick arrived while the dispatcher was busy");

endmodule

bind dispatch_fsm sample_cluster_properties u_properties (
	.clk (clk),
	.rst_n (rst_n),
	.tick (tick),
	.req (req),
	.core_load (core_load),
	.state (state)
);

// File: sample_cluster_tb.sv
`timescale 1ns/1ps

`include "cluster_consts.svh"

module sample_cluster_tb;

	import dsp_types_pkg::*;

	localparam int unsigned SEED = 32'hbd8a4da1;
	localparam int NUM_SAMPLES = 192; // Stimulus table length.
	localparam int RESULTS_TARGET = 40; // Windows to observe.
	localparam int START_LIMIT = 4 * `SAMPLE_PERIOD;
	localparam int RUN_LIMIT = (RESULTS_TARGET + 2) * `WINDOW * `SAMPLE_PERIOD + 100;
	localparam sample_t SAMPLE_MAX = {1'b0, {(`SAMPLE_W - 1){1'b1}}};
	localparam sample_t SAMPLE_MIN = {1'b1, {(`SAMPLE_W - 1){1'b0}}};

	logic clk;
	logic rst_n;
	sample_t sample;
	logic req;
	core_out_t core_out [`CORE_COUNT];

	sample_t stim [NUM_SAMPLES];
	result_t exp_q [`CORE_COUNT][$]; // Expected sums per core.
	longint part_sum [`CORE_COUNT] = '{default: 0};
	int part_cnt [`CORE_COUNT] = '{default: 0};
	int n_sent = 0; // Samples handed out so far.
	int results_seen = 0;
	int next_core = 0; // Core due for the next result.
	int reset_edges = 0;
	int run_edges = 0;
	int last_req_edge = -1;
	logic req_prev = 1'b0;
	int value_errors = 0;
	int other_errors = 0;
	int waited;

	initial clk = 1'b0;
	always #2 clk = ~clk;

	sample_cluster uut (
		.clk (clk),
		.rst_n (rst_n),
		.sample (sample),
		.req (req),
		.core_out (core_out)
	);

	// ======================================================================
	// Compare tasks
	// ======================================================================

	task automatic check_result(input string name, input result_t expected,
		input result_t actual);
		if (actual !== expected) begin
			value_errors++;
			$display("ERROR %s: expected %0d, got %0d", name, expected, actual);
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			value_errors++;
			$display("ERROR %s: expected %b, got %b", name, expected, actual);
		end
	endtask

	// ======================================================================
	// Stimulus and reference model
	// ======================================================================

	// Full windows of extremes first, then random with extremes mixed in.
	function automatic sample_t make_sample(input int n);
		int unsigned pick;
		if (n >= 16 && n < 32) begin
			return SAMPLE_MAX;
		end
		if (n >= 32 && n < 48) begin
			return SAMPLE_MIN;
		end
		pick = $urandom % 8;
		if (pick == 0) begin
			return SAMPLE_MAX;
		end
		if (pick == 1) begin
			return SAMPLE_MIN;
		end
		return sample_t'($urandom);
	endfunction

	// Sample n belongs to core n mod CORE_COUNT.
	task automatic record_sample(input sample_t s);
		int core;
		core = n_sent % `CORE_COUNT;
		part_sum[core] += longint'(s); // Wide signed sum.
		part_cnt[core]++;
		if (part_cnt[core] == `WINDOW) begin
			exp_q[core].push_back(result_t'(part_sum[core]));
			part_sum[core] = 0;
			part_cnt[core] = 0;
		end
		n_sent++;
	endtask

	// ======================================================================
	// Output monitors
	// ======================================================================

	task automatic expect_quiet(input string phase);
		check_flag({phase, " req"}, 1'b0, req);
		for (int i = 0; i < `CORE_COUNT; i++) begin
			check_flag($sformatf("%s core %0d en", phase, i), 1'b0, core_out[i].en);
		end
	endtask

	task automatic track_requests();
		if (req === 1'b1) begin
			check_flag("req width", 1'b0, req_prev);
			if (last_req_edge >= 0 && run_edges - last_req_edge != `SAMPLE_PERIOD) begin
				value_errors++;
				$display("ERROR req spacing: expected %0d, got %0d", `SAMPLE_PERIOD,
					run_edges - last_req_edge);
			end
			last_req_edge = run_edges;
		end
		req_prev = req;
	endtask

	task automatic observe_results();
		int hits;
		hits = 0;
		for (int i = 0; i < `CORE_COUNT; i++) begin
			if (core_out[i].en === 1'b1) begin
				hits++;
				if (exp_q[i].size() == 0) begin
					other_errors++;
					$display("Core %0d raised a result with no finished window in the model", i);
				end else begin
					check_result($sformatf("core %0d window sum", i), exp_q[i].pop_front(),
						core_out[i].data);
				end
			end
		end
		if (hits > 1) begin
			other_errors++;
			$display("More than one core raised its enable in the same cycle");
		end
		if (hits > 0) begin
			check_flag($sformatf("rotation core %0d en", next_core), 1'b1,
				core_out[next_core].en);
			next_core = (next_core + 1) % `CORE_COUNT;
			results_seen += hits;
		end
	endtask

	// Values read here are the ones from the cycle that just ended.
	always @(posedge clk) begin
		if (rst_n !== 1'b1) begin
			reset_edges++;
			if (reset_edges > 1) begin
				expect_quiet("reset");
			end
			run_edges = 0;
			req_prev = 1'b0;
		end else begin
			run_edges++;
			if (run_edges <= `SAMPLE_PERIOD) begin
				expect_quiet("startup");
			end
			track_requests();
			observe_results();
			if (req === 1'b1) begin
				sample <= stim[n_sent % NUM_SAMPLES]; // Source answers the request.
				record_sample(stim[n_sent % NUM_SAMPLES]);
			end
		end
	end

	// ======================================================================
	// Run control
	// ======================================================================

	initial begin
		rst_n = 1'b0;
		sample = '0;
		void'($urandom(SEED));
		for (int n = 0; n < NUM_SAMPLES; n++) begin
			stim[n] = make_sample(n);
		end
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;

		waited = 0;
		while (n_sent == 0 && waited < START_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (n_sent == 0) begin
			other_errors++;
			$display("No sample request arrived after reset was released");
		end

		waited = 0;
		while (results_seen < RESULTS_TARGET && waited < RUN_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (results_seen < RESULTS_TARGET) begin
			other_errors++;
			$display("Timed out with %0d of %0d window results seen", results_seen,
				RESULTS_TARGET);
		end

		$display("Errors: %0d value mismatches, %0d other failures", value_errors,
			other_errors);
		if (value_errors + other_errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: sample_cluster.f
+incdir+.
dsp_types_pkg.sv
ctrl_pkg.sv
pace_timer.sv
dispatch_fsm.sv
window_core.sv
sample_cluster.sv
sample_cluster_properties.sv
sample_cluster_tb.sv
